/* all.f */
logic/qos_pkg.sv
logic/arb_pkg.sv
logic/wait_tracker.sv
logic/score_stage.sv
logic/select_stage.sv
logic/grant_stage.sv
logic/perf_monitor.sv
logic/qos_arbiter_top.sv
verif/qos_arbiter_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = qos_arbiter_tb
FILELIST = all.f
OBJDIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJDIR)

/* verif/qos_arbiter_tb.sv */
// ---------------------------------------------------------------------
// Testbench for the QoS arbiter
// Clock, reset, requester models, accept bookkeeping
// Concurrent assertions for reset, grants, modes and monitoring
// ---------------------------------------------------------------------

module qos_arbiter_tb;

    // Cycle budget per phase for the watchdog
    localparam int RST_CYC  = 16;
    localparam int RR_CYC   = 40;
    localparam int BP_CYC   = 20;
    localparam int PRIO_CYC = 40;
    localparam int FIX_CYC  = 60;
    localparam int DRAIN    = 60;
    localparam int WATCHDOG = (RST_CYC + RR_CYC + BP_CYC + PRIO_CYC + FIX_CYC + 4 * DRAIN) * 10;
    // Cycles allowed for the starvation flag after requester 3 goes valid
    localparam int STARVE_DL = int'(arb_pkg::STARVE_WAIT) + int'(arb_pkg::STARVE_LIMIT) + 8;

    logic                      clk_i = 1'b0;
    logic                      rst_ni = 1'b0;
    logic [3:0]                req_valid = '0;
    qos_pkg::qos_cfg_t [3:0]   qos_cfg = '0;
    logic [3:0][31:0]          req_addr = '0;
    logic [3:0][31:0]          req_data = '0;
    logic [3:0]                req_write = '0;
    logic [3:0]                req_ready_o;
    logic                      arb_valid_o;
    qos_pkg::qos_cfg_t         arb_qos_o;
    logic [31:0]               arb_addr_o;
    logic [31:0]               arb_data_o;
    logic                      arb_write_o;
    logic                      arb_ready = 1'b0;
    logic                      qos_enable = 1'b0;
    arb_pkg::arb_mode_e        arb_mode = arb_pkg::MODE_RR;
    logic [31:0]               total_requests_o;
    logic [31:0]               qos_violations_o;
    logic [3:0]                starve_flags_o;

    // Requester model controls and phase flags
    logic [3:0] want = '0;
    logic       rst_window = 1'b1;
    logic       rr_phase = 1'b0;
    logic       prio_phase = 1'b0;
    logic       fix_phase = 1'b0;
    logic       mon_check = 1'b0;
    // Bookkeeping of accepts
    int         errors = 0;
    int         acc_count = 0;
    logic [1:0] last_id [3];
    int         last_n = 0;
    logic [3:0] recent;
    logic [1:0] acc_idx;
    logic       prio_seen = 1'b0;
    logic       starve_seen = 1'b0;
    int         fix_cycles = 0;
    int         seed = 32'h22093319;

    qos_arbiter_top dut0 (
        .clk_i, .rst_ni, .req_valid_i(req_valid), .qos_cfg_i(qos_cfg),
        .req_addr_i(req_addr), .req_data_i(req_data), .req_write_i(req_write),
        .req_ready_o, .arb_valid_o, .arb_qos_o, .arb_addr_o, .arb_data_o,
        .arb_write_o, .arb_ready_i(arb_ready), .qos_enable_i(qos_enable),
        .arb_mode_i(arb_mode), .total_requests_o, .qos_violations_o, .starve_flags_o
    );

    always #5 clk_i = ~clk_i;

    task automatic report_mismatch(input string name, input string got, input string exp);
        errors++;
        $display("FAIL %0t %s got %s expected %s", $time, name, got, exp);
    endtask

    task automatic flag_problem(input string what);
        errors++;
        $display("ERROR %0t %s", $time, what);
    endtask

    // ---------------------------------------------------------------------
    // Requester models hold until ready, then renew or drop
    // ---------------------------------------------------------------------
    always @(posedge clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if ((req_valid[i] && req_ready_o[i]) || (!req_valid[i] && want[i])) begin
                req_valid[i] <= want[i];
                // Address tagged with the requester index in the top nibble
                req_addr[i]  <= {4'(i), 28'($random(seed))};
                req_data[i]  <= 32'($random(seed));
                req_write[i] <= 1'($random(seed));
            end
        end
    end

    // Accept index and recent history from the ready bits
    always_comb begin
        acc_idx = '0;
        recent  = '0;
        for (int i = 0; i < 4; i++) begin
            if (req_ready_o[i]) acc_idx = 2'(i);
        end
        for (int k = 0; k < 3; k++) begin
            if (k < last_n) recent[last_id[k]] = 1'b1;
        end
    end

    always @(posedge clk_i) begin
        if (rst_ni && |req_ready_o) begin
            acc_count  <= acc_count + 1;
            last_id[2] <= last_id[1];
            last_id[1] <= last_id[0];
            last_id[0] <= acc_idx;
            last_n     <= (last_n < 3) ? last_n + 1 : 3;
            if (prio_phase) prio_seen <= 1'b1;
        end
        // History only spans the round-robin phase
        if (!rr_phase) last_n <= 0;
        if (fix_phase && req_valid[3]) fix_cycles <= fix_cycles + 1;
        if (fix_phase && starve_flags_o[3]) starve_seen <= 1'b1;
    end

    // ---------------------------------------------------------------------
    // Checks
    // ---------------------------------------------------------------------
    a_rst_valid: assert property (@(posedge clk_i) rst_window |->
            !arb_valid_o && req_ready_o == 0)
        else flag_problem("grant activity during or right after reset");
    a_rst_mon: assert property (@(posedge clk_i) rst_window |->
            starve_flags_o == 0 && total_requests_o == 0 && qos_violations_o == 0)
        else flag_problem("monitor outputs not clear during or right after reset");
    a_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(req_ready_o))
        else report_mismatch("req_ready_o", $sformatf("%b", $sampled(req_ready_o)), "one-hot");
    a_ready_ok: assert property (@(posedge clk_i) disable iff (!rst_ni) |req_ready_o |->
            arb_valid_o && arb_ready && (req_ready_o & ~req_valid) == 0)
        else flag_problem("ready given without a valid request and memory handshake");
    a_bp: assert property (@(posedge clk_i) disable iff (!rst_ni) !arb_ready |-> req_ready_o == 0)
        else report_mismatch("req_ready_o", $sformatf("%b", $sampled(req_ready_o)), "0");
    a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni) |req_ready_o |->
            arb_addr_o == req_addr[acc_idx])
        else report_mismatch("arb_addr_o", $sformatf("%h", $sampled(arb_addr_o)),
                             $sformatf("%h", $sampled(req_addr[acc_idx])));
    a_data: assert property (@(posedge clk_i) disable iff (!rst_ni) |req_ready_o |->
            arb_data_o == req_data[acc_idx])
        else report_mismatch("arb_data_o", $sformatf("%h", $sampled(arb_data_o)),
                             $sformatf("%h", $sampled(req_data[acc_idx])));
    a_write: assert property (@(posedge clk_i) disable iff (!rst_ni) |req_ready_o |->
            arb_write_o == req_write[acc_idx])
        else report_mismatch("arb_write_o", $sformatf("%b", $sampled(arb_write_o)),
                             $sformatf("%b", $sampled(req_write[acc_idx])));
    a_qos: assert property (@(posedge clk_i) disable iff (!rst_ni) |req_ready_o |->
            arb_qos_o == qos_cfg[acc_idx])
        else report_mismatch("arb_qos_o", $sformatf("%h", $sampled(arb_qos_o)),
                             $sformatf("%h", $sampled(qos_cfg[acc_idx])));
    a_rr: assert property (@(posedge clk_i) disable iff (!rst_ni)
            rr_phase |-> (req_ready_o & recent) == 0)
        else flag_problem("round robin accepted a requester twice within four accepts");
    a_prio: assert property (@(posedge clk_i) disable iff (!rst_ni)
            prio_phase && !prio_seen && |req_ready_o |-> req_ready_o[2])
        else report_mismatch("req_ready_o", $sformatf("%b", $sampled(req_ready_o)), "0100");
    a_fixed: assert property (@(posedge clk_i) disable iff (!rst_ni)
            fix_phase && |req_ready_o |-> req_ready_o[0])
        else report_mismatch("req_ready_o", $sformatf("%b", $sampled(req_ready_o)), "0001");
    a_starve: assert property (@(posedge clk_i) disable iff (!rst_ni)
            fix_phase && fix_cycles == STARVE_DL |-> starve_seen || starve_flags_o[3])
        else flag_problem("starvation flag of requester 3 did not rise in time");
    a_viol: assert property (@(posedge clk_i) mon_check |-> qos_violations_o != 0)
        else report_mismatch("qos_violations_o", "0", "nonzero");
    a_total: assert property (@(posedge clk_i) mon_check |-> total_requests_o == acc_count)
        else report_mismatch("total_requests_o", $sformatf("%0d", $sampled(total_requests_o)),
                             $sformatf("%0d", $sampled(acc_count)));

    // ---------------------------------------------------------------------
    // Phase sequence
    // ---------------------------------------------------------------------
    task automatic drain();
        @(posedge clk_i);
        while (req_valid != 0) @(posedge clk_i);
        repeat (3) @(posedge clk_i);
    endtask

    initial begin
        // Latency budget wide enough that only the fixed-mode phase violates it
        for (int i = 0; i < 4; i++) begin
            qos_cfg[i].urgent      <= 1'b0;
            qos_cfg[i].real_time   <= 1'b0;
            qos_cfg[i].max_latency <= 10'd1000;
        end
        repeat (RST_CYC) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);
        // Round robin with all four busy
        rst_window <= 1'b0;
        arb_ready  <= 1'b1;
        want       <= 4'hf;
        rr_phase   <= 1'b1;
        repeat (RR_CYC) @(posedge clk_i);
        // Back-pressure then release
        arb_ready <= 1'b0;
        rr_phase  <= 1'b0;
        repeat (BP_CYC) @(posedge clk_i);
        want      <= 4'h0;
        arb_ready <= 1'b1;
        drain();
        // Priority from idle with distinct levels and requester 2 highest
        qos_cfg[0].qos_level <= 4'd1;
        qos_cfg[1].qos_level <= 4'd5;
        qos_cfg[2].qos_level <= 4'd9;
        qos_cfg[3].qos_level <= 4'd3;
        qos_enable <= 1'b1;
        arb_mode   <= arb_pkg::MODE_PRIO;
        @(posedge clk_i);
        want       <= 4'hf;
        prio_phase <= 1'b1;
        while (!prio_seen) @(posedge clk_i);
        want       <= 4'h0;
        prio_phase <= 1'b0;
        drain();
        // Requester 3 starves behind requester 0 in fixed mode
        arb_mode               <= arb_pkg::MODE_FIXED_A;
        qos_cfg[3].max_latency <= 10'd4;
        @(posedge clk_i);
        want      <= 4'b1001;
        fix_phase <= 1'b1;
        repeat (FIX_CYC) @(posedge clk_i);
        fix_phase <= 1'b0;
        want      <= 4'h0;
        drain();
        mon_check <= 1'b1;
        @(posedge clk_i);
        mon_check <= 1'b0;
        repeat (2) @(posedge clk_i);
        $display("errors: %0d, accepts: %0d", errors, acc_count);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog over all phases plus drain margin
    initial begin
        #(WATCHDOG);
        $display("Run did not finish within %0d time units", WATCHDOG);
        $display("sim failed");
        $finish;
    end

endmodule

/* logic/qos_arbiter_top.sv */
// ---------------------------------------------------------------------
// QoS arbiter top level
// Score and select pipeline, grant mux, wait tracking, monitoring
// ---------------------------------------------------------------------

module qos_arbiter_top #(
    parameter int unsigned NUM_REQ = 4,
    parameter int unsigned ADDR_W  = 32,
    parameter int unsigned DATA_W  = 32,
    localparam int unsigned IDX_W  = $clog2(NUM_REQ)
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // Requester side
    input  logic [NUM_REQ-1:0]              req_valid_i,
    input  qos_pkg::qos_cfg_t [NUM_REQ-1:0] qos_cfg_i,
    input  logic [NUM_REQ-1:0][ADDR_W-1:0]  req_addr_i,
    input  logic [NUM_REQ-1:0][DATA_W-1:0]  req_data_i,
    input  logic [NUM_REQ-1:0]              req_write_i,
    output logic [NUM_REQ-1:0]              req_ready_o,
    // Memory side
    output logic                            arb_valid_o,
    output qos_pkg::qos_cfg_t               arb_qos_o,
    output logic [ADDR_W-1:0]               arb_addr_o,
    output logic [DATA_W-1:0]               arb_data_o,
    output logic                            arb_write_o,
    input  logic                            arb_ready_i,
    // Configuration levels
    input  logic                            qos_enable_i,
    input  arb_pkg::arb_mode_e              arb_mode_i,
    // Monitoring
    output logic [arb_pkg::CNT_W-1:0]       total_requests_o,
    output logic [arb_pkg::CNT_W-1:0]       qos_violations_o,
    output logic [NUM_REQ-1:0]              starve_flags_o
);

    logic [NUM_REQ-1:0][arb_pkg::WAIT_W-1:0]  wait_cnt;
    logic [NUM_REQ-1:0][qos_pkg::SCORE_W-1:0] score_q;
    logic [NUM_REQ-1:0]                       valid_q;
    logic                                     win_valid_q;
    logic [IDX_W-1:0]                         win_id_q;
    logic                                     accept;
    logic [IDX_W-1:0]                         accept_id;

    wait_tracker #(.NUM_REQ(NUM_REQ)) u_wait (
        .clk_i, .rst_ni, .req_valid_i,
        .accept_i(accept), .accept_id_i(accept_id),
        .wait_cnt_o(wait_cnt), .starve_flags_o
    );

    score_stage #(.NUM_REQ(NUM_REQ)) u_score (
        .clk_i, .rst_ni, .req_valid_i, .qos_cfg_i, .qos_enable_i,
        .wait_cnt_i(wait_cnt), .score_o(score_q), .valid_o(valid_q)
    );

    select_stage #(.NUM_REQ(NUM_REQ)) u_select (
        .clk_i, .rst_ni, .arb_mode_i, .valid_i(valid_q), .score_i(score_q),
        .win_valid_o(win_valid_q), .win_id_o(win_id_q)
    );

    grant_stage #(.NUM_REQ(NUM_REQ), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_grant (
        .win_valid_i(win_valid_q), .win_id_i(win_id_q),
        .req_valid_i, .qos_cfg_i, .req_addr_i, .req_data_i, .req_write_i,
        .arb_ready_i, .arb_valid_o, .arb_qos_o, .arb_addr_o, .arb_data_o,
        .arb_write_o, .req_ready_o, .accept_o(accept), .accept_id_o(accept_id)
    );

    perf_monitor #(.NUM_REQ(NUM_REQ)) u_perf (
        .clk_i, .rst_ni, .accept_i(accept), .req_valid_i, .qos_cfg_i,
        .wait_cnt_i(wait_cnt), .total_requests_o, .qos_violations_o
    );

endmodule

/* logic/perf_monitor.sv */
// ---------------------------------------------------------------------
// Performance monitor
// Accepted transfer count and QoS latency violation count
// ---------------------------------------------------------------------

module perf_monitor #(
    parameter int unsigned NUM_REQ = 4
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    accept_i,
    input  logic [NUM_REQ-1:0]                      req_valid_i,
    input  qos_pkg::qos_cfg_t [NUM_REQ-1:0]         qos_cfg_i,
    input  logic [NUM_REQ-1:0][arb_pkg::WAIT_W-1:0] wait_cnt_i,
    output logic [arb_pkg::CNT_W-1:0]               total_requests_o,
    output logic [arb_pkg::CNT_W-1:0]               qos_violations_o
);

    logic [arb_pkg::CNT_W-1:0] total_q;
    logic [arb_pkg::CNT_W-1:0] viol_q;
    // Some valid requester is past its latency budget
    logic                      any_late;

    always_comb begin
        any_late = 1'b0;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (req_valid_i[i] &&
                wait_cnt_i[i] > arb_pkg::WAIT_W'(qos_cfg_i[i].max_latency)) begin
                any_late = 1'b1;
            end
        end
    end

    // Both counters wrap
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            total_q <= '0;
            viol_q  <= '0;
        end else begin
            if (accept_i) begin
                total_q <= total_q + 1'b1;
            end
            // One per cycle, however many requesters are late
            if (any_late) begin
                viol_q <= viol_q + 1'b1;
            end
        end
    end

    assign total_requests_o = total_q;
    assign qos_violations_o = viol_q;

endmodule

/* logic/grant_stage.sv */
// ---------------------------------------------------------------------
// Grant stage
// Presents the winner to memory, muxes payload, forms request ready
// ---------------------------------------------------------------------

module grant_stage #(
    parameter int unsigned NUM_REQ = 4,
    parameter int unsigned ADDR_W  = 32,
    parameter int unsigned DATA_W  = 32,
    localparam int unsigned IDX_W  = $clog2(NUM_REQ)
) (
    input  logic                            win_valid_i,
    input  logic [IDX_W-1:0]                win_id_i,
    input  logic [NUM_REQ-1:0]              req_valid_i,
    input  qos_pkg::qos_cfg_t [NUM_REQ-1:0] qos_cfg_i,
    input  logic [NUM_REQ-1:0][ADDR_W-1:0]  req_addr_i,
    input  logic [NUM_REQ-1:0][DATA_W-1:0]  req_data_i,
    input  logic [NUM_REQ-1:0]              req_write_i,
    input  logic                            arb_ready_i,
    output logic                            arb_valid_o,
    output qos_pkg::qos_cfg_t               arb_qos_o,
    output logic [ADDR_W-1:0]               arb_addr_o,
    output logic [DATA_W-1:0]               arb_data_o,
    output logic                            arb_write_o,
    output logic [NUM_REQ-1:0]              req_ready_o,
    output logic                            accept_o,
    output logic [IDX_W-1:0]                accept_id_o
);

    // Stale choice dropped once the requester lets go
    logic present;

    assign present = win_valid_i && req_valid_i[win_id_i];

    assign arb_valid_o = present;

    // Payload of the presented winner, zero otherwise
    assign arb_qos_o   = present ? qos_cfg_i[win_id_i] : '0;
    assign arb_addr_o  = present ? req_addr_i[win_id_i] : '0;
    assign arb_data_o  = present ? req_data_i[win_id_i] : '0;
    assign arb_write_o = present && req_write_i[win_id_i];

    // Memory-side handshake completes the transfer
    assign accept_o    = present && arb_ready_i;
    assign accept_id_o = win_id_i;

    // One-hot ready for the accepted requester
    always_comb begin
        req_ready_o = '0;
        if (accept_o) begin
            req_ready_o[win_id_i] = 1'b1;
        end
    end

endmodule

/* logic/select_stage.sv */
// ---------------------------------------------------------------------
// Second pipeline stage
// Registers a winner by arbitration mode, holds the round-robin pointer
// ---------------------------------------------------------------------

module select_stage #(
    parameter int unsigned NUM_REQ = 4,
    localparam int unsigned IDX_W  = $clog2(NUM_REQ)
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  arb_pkg::arb_mode_e                       arb_mode_i,
    input  logic [NUM_REQ-1:0]                       valid_i,
    input  logic [NUM_REQ-1:0][qos_pkg::SCORE_W-1:0] score_i,
    output logic                                     win_valid_o,
    output logic [IDX_W-1:0]                         win_id_o
);

    // Next winner, combinational
    logic             pick_valid;
    logic [IDX_W-1:0] pick_id;

    // Registered winner and round-robin pointer
    logic             win_valid_q;
    logic [IDX_W-1:0] win_id_q;
    logic [IDX_W-1:0] rr_ptr_q;

    // ---------------------------------------------------------------------
    // Winner choice
    // ---------------------------------------------------------------------

    always_comb begin : choose
        int                        idx;
        logic [qos_pkg::SCORE_W-1:0] best_score;
        pick_valid = 1'b0;
        pick_id    = '0;
        best_score = '0;
        idx        = 0;
        case (arb_mode_i)
            arb_pkg::MODE_RR: begin
                // First valid at or after the pointer, wrapping
                for (int k = 0; k < NUM_REQ; k++) begin
                    idx = (int'(rr_ptr_q) + k) % NUM_REQ;
                    if (!pick_valid && valid_i[idx]) begin
                        pick_valid = 1'b1;
                        pick_id    = IDX_W'(idx);
                    end
                end
            end
            arb_pkg::MODE_PRIO: begin
                // Strictly greater, so ties stay with the lower index
                for (int i = 0; i < NUM_REQ; i++) begin
                    if (valid_i[i] && (!pick_valid || score_i[i] > best_score)) begin
                        pick_valid = 1'b1;
                        pick_id    = IDX_W'(i);
                        best_score = score_i[i];
                    end
                end
            end
            arb_pkg::MODE_FIXED_A, arb_pkg::MODE_FIXED_B: begin
                // Lowest valid index
                for (int i = 0; i < NUM_REQ; i++) begin
                    if (!pick_valid && valid_i[i]) begin
                        pick_valid = 1'b1;
                        pick_id    = IDX_W'(i);
                    end
                end
            end
        endcase
    end

    // ---------------------------------------------------------------------
    // Winner and pointer registers
    // ---------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            win_valid_q <= 1'b0;
            win_id_q    <= '0;
            rr_ptr_q    <= '0;
        end else begin
            win_valid_q <= pick_valid;
            win_id_q    <= pick_id;
            // Pointer moves past every registered winner
            if (pick_valid) begin
                rr_ptr_q <= IDX_W'((int'(pick_id) + 1) % NUM_REQ);
            end
        end
    end

    assign win_valid_o = win_valid_q;
    assign win_id_o    = win_id_q;

endmodule

/* logic/score_stage.sv */
// ---------------------------------------------------------------------
// First pipeline stage
// Registers a priority score and the valid bit per requester
// ---------------------------------------------------------------------

module score_stage #(
    parameter int unsigned NUM_REQ = 4
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic [NUM_REQ-1:0]                       req_valid_i,
    input  qos_pkg::qos_cfg_t [NUM_REQ-1:0]          qos_cfg_i,
    input  logic                                     qos_enable_i,
    input  logic [NUM_REQ-1:0][arb_pkg::WAIT_W-1:0]  wait_cnt_i,
    output logic [NUM_REQ-1:0][qos_pkg::SCORE_W-1:0] score_o,
    output logic [NUM_REQ-1:0]                       valid_o
);

    // Two guard bits hold the carry of four addends
    localparam int unsigned SUM_W = qos_pkg::SCORE_W + 2;

    logic [NUM_REQ-1:0][qos_pkg::SCORE_W-1:0] score_d;
    logic [NUM_REQ-1:0][qos_pkg::SCORE_W-1:0] score_q;
    logic [NUM_REQ-1:0]                       valid_q;

    always_comb begin : calc_score
        logic [SUM_W-1:0] sum;
        for (int i = 0; i < NUM_REQ; i++) begin
            // Level base plus bonuses plus aging
            sum = (SUM_W'(qos_cfg_i[i].qos_level) << qos_pkg::LEVEL_SHIFT)
                + (qos_cfg_i[i].urgent ? SUM_W'(qos_pkg::URGENT_BONUS) : '0)
                + (qos_cfg_i[i].real_time ? SUM_W'(qos_pkg::RT_BONUS) : '0)
                + SUM_W'(wait_cnt_i[i]);
            if (qos_enable_i && req_valid_i[i]) begin
                // Saturate at the top of the score range
                score_d[i] = (|sum[SUM_W-1:qos_pkg::SCORE_W]) ? '1 : sum[qos_pkg::SCORE_W-1:0];
            end else begin
                // Aging only
                score_d[i] = qos_pkg::SCORE_W'(wait_cnt_i[i]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        score_q <= score_d;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= req_valid_i;
        end
    end

    assign score_o = score_q;
    assign valid_o = valid_q;

endmodule

/* logic/wait_tracker.sv */
// ---------------------------------------------------------------------
// Per-requester wait counters
// Starvation counters and starvation flags
// ---------------------------------------------------------------------

module wait_tracker #(
    parameter int unsigned NUM_REQ = 4,
    localparam int unsigned IDX_W  = $clog2(NUM_REQ)
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic [NUM_REQ-1:0]                      req_valid_i,
    input  logic                                    accept_i,
    input  logic [IDX_W-1:0]                        accept_id_i,
    output logic [NUM_REQ-1:0][arb_pkg::WAIT_W-1:0] wait_cnt_o,
    output logic [NUM_REQ-1:0]                      starve_flags_o
);

    // Cycles waited so far, per requester
    logic [NUM_REQ-1:0][arb_pkg::WAIT_W-1:0] wait_q;
    // Cycles spent beyond the starvation wait
    logic [NUM_REQ-1:0][arb_pkg::WAIT_W-1:0] starve_q;
    // One-hot acceptance per requester
    logic [NUM_REQ-1:0]                      acc_hit;

    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) begin
            acc_hit[i] = accept_i && (accept_id_i == IDX_W'(i));
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_q   <= '0;
            starve_q <= '0;
        end else begin
            for (int i = 0; i < NUM_REQ; i++) begin
                // Wait count, cleared on accept or idle
                if (acc_hit[i] || !req_valid_i[i]) begin
                    wait_q[i] <= '0;
                end else if (wait_q[i] != '1) begin
                    wait_q[i] <= wait_q[i] + 1'b1;
                end
                // Starvation count, cleared on accept only
                if (acc_hit[i]) begin
                    starve_q[i] <= '0;
                end else if (wait_q[i] > arb_pkg::STARVE_WAIT && starve_q[i] != '1) begin
                    starve_q[i] <= starve_q[i] + 1'b1;
                end
            end
        end
    end

    assign wait_cnt_o = wait_q;

    // Flag stays up while starvation count is over the limit
    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) begin
            starve_flags_o[i] = starve_q[i] > arb_pkg::STARVE_LIMIT;
        end
    end

endmodule

/* logic/arb_pkg.sv */
// ---------------------------------------------------------------------
// Arbitration-side definitions
// Mode encoding, wait and counter widths, starvation thresholds
// ---------------------------------------------------------------------

package arb_pkg;

    // Arbitration mode, both fixed codes select lowest index
    typedef enum logic [1:0] {
        MODE_RR      = 2'd0,
        MODE_PRIO    = 2'd1,
        MODE_FIXED_A = 2'd2,
        MODE_FIXED_B = 2'd3
    } arb_mode_e;

    // Saturating wait counter width
    localparam int unsigned WAIT_W = 16;

    // Wait above which a requester accrues starvation
    localparam logic [WAIT_W-1:0] STARVE_WAIT = 16'd16;

    // Starvation count above which the flag is raised
    localparam logic [WAIT_W-1:0] STARVE_LIMIT = 16'd8;

    // Performance counter width
    localparam int unsigned CNT_W = 32;

endpackage

/* logic/qos_pkg.sv */
// ---------------------------------------------------------------------
// Request-side definitions
// QoS descriptor carried with every request, score width and weights
// ---------------------------------------------------------------------

package qos_pkg;

    // Per-request QoS descriptor, 16 bits wide
    typedef struct packed {
        // Higher level wins under priority arbitration
        logic [3:0] qos_level;
        logic       urgent;
        logic       real_time;
        // Wait in cycles beyond which a violation is counted
        logic [9:0] max_latency;
    } qos_cfg_t;

    // ---------------------------------------------------------------------
    // Score weights
    // ---------------------------------------------------------------------

    // Width of one priority score
    localparam int unsigned SCORE_W = 16;

    // Base score is qos_level times 16
    localparam int unsigned LEVEL_SHIFT = 4;

    // Bonus for urgent requests
    localparam logic [SCORE_W-1:0] URGENT_BONUS = 16'd64;

    // Bonus for real-time requests
    localparam logic [SCORE_W-1:0] RT_BONUS = 16'd32;

endpackage
